//--- design/mac_reg_pkg.sv
package mac_reg_pkg;

    localparam logic [11:0] addr_status = 12'h000;
    localparam logic [11:0] addr_txlen  = 12'h004;
    localparam logic [11:0] addr_txfifo = 12'h008;
    localparam logic [11:0] addr_txctrl = 12'h00C;
    localparam logic [11:0] addr_txdis  = 12'h010;
    localparam logic [11:0] addr_rxlen  = 12'h014;
    localparam logic [11:0] addr_rxfifo = 12'h018;
    localparam logic [11:0] addr_rxctrl = 12'h01C;
    localparam logic [11:0] addr_rxdis  = 12'h020;
    localparam logic [11:0] addr_ie     = 12'h024;
    localparam logic [11:0] addr_ip     = 12'h028;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // one-cycle strobes from the register block
    typedef struct packed {
        logic        len_wr;
        logic        ctrl_wr;
        logic        word_wr;
        logic        dis;
        logic [31:0] wdata;
    } tx_cmd_t;

    typedef struct packed {
        logic ctrl_wr;
        logic word_rd;
        logic dis;
        logic wdata0;
    } rx_cmd_t;

    typedef struct packed {
        logic [10:0] tx_len;
        logic        tx_en;
        logic        busy;
    } tx_status_t;

    typedef struct packed {
        logic [10:0] rx_len;
        logic        rx_en;
        logic        busy;
        logic        frame_ready;
        logic [31:0] rx_data;
    } rx_status_t;

endpackage

//--- design/mac_stream_pkg.sv
package mac_stream_pkg;

    localparam int word_w         = 32;
    localparam int len_w          = 11;
    localparam int ram_aw         = 9;
    localparam int len_fifo_depth = 4;
    localparam int len_fifo_aw    = $clog2(len_fifo_depth);
    localparam int stream_credits = 4;
    localparam int credit_w       = $clog2(stream_credits + 1);

    // nbytes is 1 to 4, only meaningful with valid
    typedef struct packed {
        logic              valid;
        logic              last;
        logic              error;
        logic [2:0]        nbytes;
        logic [word_w-1:0] data;
    } stream_word_t;

    // byte length to word count, rounded up
    function automatic logic [ram_aw:0] len_to_words(input logic [len_w-1:0] len);
        return {1'b0, len[len_w-1:2]} + (ram_aw + 1)'(|len[1:0]);
    endfunction

endpackage

//--- design/mac_apb_regs.sv
`timescale 1ns/100ps

module mac_apb_regs (
    input  logic                    clk,
    input  logic                    sw_rstn,
    input  mac_reg_pkg::apb_req_t   apb,
    input  mac_reg_pkg::tx_status_t tx_status,
    input  mac_reg_pkg::rx_status_t rx_status,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output mac_reg_pkg::tx_cmd_t    tx_cmd,
    output mac_reg_pkg::rx_cmd_t    rx_cmd,
    output logic                    irq
);
    import mac_reg_pkg::*;

    logic        setup;
    logic        wr;
    logic        rd;
    logic        tx_ie;
    logic        rx_ie;
    logic        tx_ip;
    logic        rx_ip;
    logic [31:0] rdata;

    // decode in the setup phase, strobes last one cycle
    assign setup = apb.psel && !apb.penable;
    assign wr    = setup && apb.pwrite;
    assign rd    = setup && !apb.pwrite;

    assign tx_cmd.len_wr  = wr && apb.paddr == addr_txlen;
    assign tx_cmd.ctrl_wr = wr && apb.paddr == addr_txctrl;
    assign tx_cmd.word_wr = wr && apb.paddr == addr_txfifo;
    assign tx_cmd.dis     = wr && apb.paddr == addr_txdis;
    assign tx_cmd.wdata   = apb.pwdata;

    assign rx_cmd.ctrl_wr = wr && apb.paddr == addr_rxctrl;
    assign rx_cmd.word_rd = rd && apb.paddr == addr_rxfifo;
    assign rx_cmd.dis     = wr && apb.paddr == addr_rxdis;
    assign rx_cmd.wdata0  = apb.pwdata[0];

    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    always_ff @(posedge clk or negedge sw_rstn) begin
        if (!sw_rstn) begin
            tx_ie <= 1'b0;
            rx_ie <= 1'b0;
        end else if (wr && apb.paddr == addr_ie) begin
            tx_ie <= apb.pwdata[0];
            rx_ie <= apb.pwdata[1];
        end
    end

    assign tx_ip = !tx_status.busy;
    assign rx_ip = rx_status.frame_ready;
    assign irq   = (tx_ip && tx_ie) || (rx_ip && rx_ie);

    always_comb begin
        rdata = '0;
        case (apb.paddr)
            addr_status: rdata = {tx_status.busy, rx_status.busy, 30'b0};
            addr_txlen:  rdata = {21'b0, tx_status.tx_len};
            addr_txfifo: rdata = {32{tx_status.tx_len == '0}};
            addr_txctrl: rdata = {31'b0, tx_status.tx_en};
            addr_rxlen:  rdata = {21'b0, rx_status.rx_len};
            addr_rxfifo: rdata = rx_status.rx_data;
            addr_rxctrl: rdata = {31'b0, rx_status.rx_en};
            addr_ie:     rdata = {30'b0, rx_ie, tx_ie};
            addr_ip:     rdata = {30'b0, rx_ip, tx_ip};
            default:     rdata = '0;
        endcase
    end

    // captured at setup, held through the access phase
    always_ff @(posedge clk or negedge sw_rstn) begin
        if (!sw_rstn) begin
            prdata <= '0;
        end else if (rd) begin
            prdata <= rdata;
        end
    end

endmodule

//--- design/mac_frame_ram.sv
`timescale 1ns/100ps

module mac_frame_ram (
    input  logic                              clk,
    input  logic                              cs,
    input  logic                              we,
    input  logic [mac_stream_pkg::ram_aw-1:0] addr,
    input  logic [mac_stream_pkg::word_w-1:0] wdata,
    output logic [mac_stream_pkg::word_w-1:0] rdata
);
    import mac_stream_pkg::*;

    logic [word_w-1:0] mem [2**ram_aw];

    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- design/mac_tx_path.sv
`timescale 1ns/100ps

module mac_tx_path (
    input  logic                         clk,
    input  logic                         sw_rstn,
    input  mac_reg_pkg::tx_cmd_t         tx_cmd,
    input  logic                         tx_credit,
    output mac_reg_pkg::tx_status_t      tx_status,
    output mac_stream_pkg::stream_word_t tx_word
);
    import mac_stream_pkg::*;

    logic                tx_en;
    logic [len_w-1:0]    tx_len;
    logic                busy;
    logic [ram_aw:0]     wr_left;
    logic [len_w-1:0]    rd_bytes;
    logic [ram_aw-1:0]   wptr;
    logic [ram_aw-1:0]   rptr;
    logic [credit_w-1:0] credits;
    logic                len_ok;
    logic                ram_wr;
    logic                ram_rd;
    logic                discard;
    logic                done;
    logic                rd_last;
    logic [2:0]          rd_nbytes;
    logic                rd_q;
    logic                last_q;
    logic [2:0]          nbytes_q;
    logic [word_w-1:0]   ram_rdata;

    assign len_ok  = tx_cmd.len_wr && tx_en && tx_len == '0;
    assign ram_wr  = tx_cmd.word_wr && wr_left != '0;
    assign discard = tx_cmd.dis && !busy;
    assign done    = tx_word.valid && tx_word.last;

    // tag for the word being fetched
    assign rd_last   = rd_bytes <= len_w'(4);
    assign rd_nbytes = rd_last ? rd_bytes[2:0] : 3'd4;

    // a credit is taken when the fetch is issued, writes win the RAM port
    assign ram_rd = busy && rd_bytes != '0 && credits != '0 && !ram_wr;

    always_ff @(posedge clk or negedge sw_rstn) begin
        if (!sw_rstn) begin
            tx_en    <= 1'b0;
            tx_len   <= '0;
            wr_left  <= '0;
            rd_bytes <= '0;
            wptr     <= '0;
            rptr     <= '0;
            busy     <= 1'b0;
            credits  <= credit_w'(stream_credits);
        end else begin
            if (tx_cmd.ctrl_wr && tx_len == '0) begin
                tx_en <= tx_cmd.wdata[0];
            end
            if (len_ok) begin
                tx_len   <= tx_cmd.wdata[len_w-1:0];
                rd_bytes <= tx_cmd.wdata[len_w-1:0];
                wr_left  <= len_to_words(tx_cmd.wdata[len_w-1:0]);
            end else if (discard) begin
                tx_len   <= '0;
                rd_bytes <= '0;
                wr_left  <= '0;
            end else begin
                if (done) begin
                    tx_len <= '0;
                end
                if (ram_wr) begin
                    wr_left <= wr_left - (ram_aw + 1)'(1);
                end
                if (ram_rd) begin
                    rd_bytes <= rd_bytes - len_w'(rd_nbytes);
                end
            end
            if (discard) begin
                wptr <= rptr;
            end else if (ram_wr) begin
                wptr <= wptr + ram_aw'(1);
            end
            if (ram_rd) begin
                rptr <= rptr + ram_aw'(1);
            end
            if (ram_wr && wr_left == (ram_aw + 1)'(1)) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            credits <= credits + credit_w'(tx_credit) - credit_w'(ram_rd);
        end
    end

    // RAM data lands one cycle after the fetch, then goes out registered
    always_ff @(posedge clk or negedge sw_rstn) begin
        if (!sw_rstn) begin
            rd_q     <= 1'b0;
            last_q   <= 1'b0;
            nbytes_q <= '0;
            tx_word  <= '0;
        end else begin
            rd_q           <= ram_rd;
            last_q         <= rd_last;
            nbytes_q       <= rd_nbytes;
            tx_word.valid  <= rd_q;
            tx_word.last   <= rd_q && last_q;
            tx_word.error  <= 1'b0;
            tx_word.nbytes <= nbytes_q;
            tx_word.data   <= ram_rdata;
        end
    end

    assign tx_status.tx_len = tx_len;
    assign tx_status.tx_en  = tx_en;
    assign tx_status.busy   = busy;

    mac_frame_ram u_tx_ram (
        .clk   (clk),
        .cs    (ram_wr || ram_rd),
        .we    (ram_wr),
        .addr  (ram_wr ? wptr : rptr),
        .wdata (tx_cmd.wdata),
        .rdata (ram_rdata)
    );

endmodule

//--- design/mac_len_fifo.sv
`timescale 1ns/100ps

module mac_len_fifo (
    input  logic                             clk,
    input  logic                             sw_rstn,
    input  logic                             write,
    input  logic [mac_stream_pkg::len_w-1:0] wdata,
    input  logic                             read,
    output logic                             full,
    output logic                             empty,
    output logic [mac_stream_pkg::len_w-1:0] rdata
);
    import mac_stream_pkg::*;

    logic [len_w-1:0]     mem [len_fifo_depth];
    logic [len_fifo_aw:0] wptr;
    logic [len_fifo_aw:0] rptr;

    assign empty = wptr == rptr;
    assign full  = wptr[len_fifo_aw] != rptr[len_fifo_aw] &&
                   wptr[len_fifo_aw-1:0] == rptr[len_fifo_aw-1:0];
    assign rdata = mem[rptr[len_fifo_aw-1:0]];

    always_ff @(posedge clk) begin
        if (write && !full) begin
            mem[wptr[len_fifo_aw-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge sw_rstn) begin
        if (!sw_rstn) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (write && !full) begin
                wptr <= wptr + (len_fifo_aw + 1)'(1);
            end
            if (read && !empty) begin
                rptr <= rptr + (len_fifo_aw + 1)'(1);
            end
        end
    end

endmodule

//--- design/mac_rx_path.sv
`timescale 1ns/100ps

module mac_rx_path (
    input  logic                         clk,
    input  logic                         sw_rstn,
    input  mac_reg_pkg::rx_cmd_t         rx_cmd,
    input  mac_stream_pkg::stream_word_t rx_word,
    output logic                         rx_credit,
    output mac_reg_pkg::rx_status_t      rx_status
);
    import mac_stream_pkg::*;

    logic                 rx_en;
    logic                 rx_en_req;
    logic                 busy;
    logic                 ovf;
    logic                 store;
    logic                 frame_end;
    logic                 end_good;
    logic                 ram_full;
    logic [ram_aw:0]      wptr;
    logic [ram_aw:0]      frame_start;
    logic [ram_aw:0]      rptr;
    logic [ram_aw:0]      tail;
    logic [len_w-1:0]     frame_len;
    logic [len_w-1:0]     end_len;
    logic [1:0]           push_q;
    logic [len_w-1:0]     push_len1;
    logic [len_w-1:0]     push_len2;
    logic [len_fifo_aw:0] held;
    logic                 fifo_empty;
    logic [len_w-1:0]     head_len;
    logic                 pop;
    logic                 head_open;
    logic                 rd_req;
    logic                 rd_q;
    logic                 data_valid;
    logic [word_w-1:0]    ram_rdata;
    logic [word_w-1:0]    rx_data;

    assign ram_full = wptr[ram_aw] != rptr[ram_aw] &&
                      wptr[ram_aw-1:0] == rptr[ram_aw-1:0];

    // one rejected word spoils the rest of the frame
    assign store     = rx_word.valid && rx_en && !ovf && !ram_full && !rx_word.error;
    assign frame_end = rx_word.valid && rx_word.last;
    assign end_len   = frame_len + len_w'(rx_word.nbytes);

    // held counts lengths queued plus those still in the push delay
    assign end_good = frame_end && store && held != (len_fifo_aw + 1)'(len_fifo_depth);
    assign pop      = rx_cmd.dis && !fifo_empty;

    always_ff @(posedge clk or negedge sw_rstn) begin
        if (!sw_rstn) begin
            rx_credit   <= 1'b0;
            rx_en_req   <= 1'b0;
            rx_en       <= 1'b0;
            busy        <= 1'b0;
            ovf         <= 1'b0;
            frame_len   <= '0;
            wptr        <= '0;
            frame_start <= '0;
            push_q      <= '0;
            held        <= '0;
        end else begin
            rx_credit <= rx_word.valid;
            if (rx_cmd.ctrl_wr) begin
                rx_en_req <= rx_cmd.wdata0;
            end
            // enable only changes between frames
            if (!busy && !rx_word.valid) begin
                rx_en <= rx_en_req;
            end
            if (rx_word.valid) begin
                busy <= !rx_word.last;
            end
            if (frame_end) begin
                ovf <= 1'b0;
            end else if (rx_word.valid && !store) begin
                ovf <= 1'b1;
            end
            if (frame_end) begin
                frame_len <= '0;
            end else if (store) begin
                frame_len <= end_len;
            end
            // a dropped frame gives back every word it stored
            if (frame_end && !end_good) begin
                wptr <= frame_start;
            end else if (store) begin
                wptr <= wptr + (ram_aw + 1)'(1);
            end
            if (end_good) begin
                frame_start <= wptr + (ram_aw + 1)'(1);
            end
            push_q <= {push_q[0], end_good};
            held   <= held + (len_fifo_aw + 1)'(end_good) - (len_fifo_aw + 1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        push_len1 <= end_len;
        push_len2 <= push_len1;
    end

    // prefetch of the head frame, never past its tail
    assign rd_req = head_open && rptr != tail && (!data_valid || rx_cmd.word_rd) &&
                    !rd_q && !store && !pop;

    always_ff @(posedge clk or negedge sw_rstn) begin
        if (!sw_rstn) begin
            head_open  <= 1'b0;
            tail       <= '0;
            rptr       <= '0;
            rd_q       <= 1'b0;
            data_valid <= 1'b0;
            rx_data    <= '0;
        end else begin
            if (pop) begin
                head_open <= 1'b0;
            end else if (!fifo_empty) begin
                head_open <= 1'b1;
            end
            if (!head_open && !fifo_empty) begin
                tail <= tail + len_to_words(head_len);
            end
            if (pop) begin
                rptr <= tail;
            end else if (rd_req) begin
                rptr <= rptr + (ram_aw + 1)'(1);
            end
            rd_q <= rd_req;
            if (pop) begin
                data_valid <= 1'b0;
            end else if (rd_q) begin
                data_valid <= 1'b1;
            end else if (rx_cmd.word_rd) begin
                data_valid <= 1'b0;
            end
            if (rd_q) begin
                rx_data <= ram_rdata;
            end
        end
    end

    assign rx_status.rx_len      = fifo_empty ? '0 : head_len;
    assign rx_status.rx_en       = rx_en;
    assign rx_status.busy        = busy;
    assign rx_status.frame_ready = !fifo_empty;
    assign rx_status.rx_data     = rx_data;

    mac_frame_ram u_rx_ram (
        .clk   (clk),
        .cs    (store || rd_req),
        .we    (store),
        .addr  (store ? wptr[ram_aw-1:0] : rptr[ram_aw-1:0]),
        .wdata (rx_word.data),
        .rdata (ram_rdata)
    );

    mac_len_fifo u_len_fifo (
        .clk     (clk),
        .sw_rstn (sw_rstn),
        .write   (push_q[1]),
        .wdata   (push_len2),
        .read    (pop),
        .full    (),
        .empty   (fifo_empty),
        .rdata   (head_len)
    );

endmodule

//--- design/mac_top.sv
`timescale 1ns/100ps

module mac_top (
    input  logic                         clk,
    input  logic                         sw_rstn,
    input  mac_reg_pkg::apb_req_t        apb,
    input  logic                         tx_credit,
    input  mac_stream_pkg::stream_word_t rx_word,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output mac_stream_pkg::stream_word_t tx_word,
    output logic                         rx_credit,
    output logic                         irq
);
    import mac_reg_pkg::*;

    tx_cmd_t    tx_cmd;
    rx_cmd_t    rx_cmd;
    tx_status_t tx_status;
    rx_status_t rx_status;

    mac_apb_regs u_regs (
        .clk       (clk),
        .sw_rstn   (sw_rstn),
        .apb       (apb),
        .tx_status (tx_status),
        .rx_status (rx_status),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .tx_cmd    (tx_cmd),
        .rx_cmd    (rx_cmd),
        .irq       (irq)
    );

    mac_tx_path u_tx (
        .clk       (clk),
        .sw_rstn   (sw_rstn),
        .tx_cmd    (tx_cmd),
        .tx_credit (tx_credit),
        .tx_status (tx_status),
        .tx_word   (tx_word)
    );

    mac_rx_path u_rx (
        .clk       (clk),
        .sw_rstn   (sw_rstn),
        .rx_cmd    (rx_cmd),
        .rx_word   (rx_word),
        .rx_credit (rx_credit),
        .rx_status (rx_status)
    );

endmodule

//--- dv/mac_tb.sv
`timescale 1ns/100ps

module mac_tb;
    import mac_reg_pkg::*;
    import mac_stream_pkg::*;

    logic         clk;
    logic         sw_rstn;
    apb_req_t     apb;
    logic         tx_credit;
    stream_word_t rx_word;
    logic [31:0]  prdata;
    logic         pready;
    logic         pslverr;
    stream_word_t tx_word;
    logic         rx_credit;
    logic         irq;

    stream_word_t tx_seen[$];
    logic [31:0]  rx_expect[$];
    int           credits_owed;
    bit           hold_credits;
    int           rx_avail;
    int           rx_credit_count;
    int           words_sent;
    int           test_errs;
    int           tests_passed;
    int           tests_failed;
    bit           timed_out;

    mac_top u_dut (
        .clk       (clk),
        .sw_rstn   (sw_rstn),
        .apb       (apb),
        .tx_credit (tx_credit),
        .rx_word   (rx_word),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .tx_word   (tx_word),
        .rx_credit (rx_credit),
        .irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // stream monitor, sampled mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (tx_word.valid) begin
                tx_seen.push_back(tx_word);
                credits_owed++;
            end
            if (rx_credit) begin
                rx_avail++;
                rx_credit_count++;
            end
        end
    end

    // credit return toward the tx path, one per cycle
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (!hold_credits && credits_owed > 0) begin
                tx_credit = 1'b1;
                credits_owed--;
            end else begin
                tx_credit = 1'b0;
            end
        end
    end

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        test_errs++;
    endtask

    task automatic note_timeout(input string what);
        $display("timeout at %0t ns: gave up waiting for %s", $time, what);
        test_errs++;
        timed_out = 1'b1;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr;
        apb.pwdata  = data;
        @(posedge clk);
        #1;
        apb.penable = 1'b1;
        if (pready !== 1'b1 || pslverr !== 1'b0) begin
            report_fail("pready low or pslverr high in a write access phase");
        end
        @(posedge clk);
        #1;
        apb = '0;
    endtask

    // prdata is captured at the end of the setup cycle
    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apb.paddr   = addr;
        @(posedge clk);
        #1;
        apb.penable = 1'b1;
        data        = prdata;
        if (pready !== 1'b1 || pslverr !== 1'b0) begin
            report_fail("pready low or pslverr high in a read access phase");
        end
        @(posedge clk);
        #1;
        apb = '0;
    endtask

    task automatic expect_reg(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        apb_read(addr, rd);
        if (rd !== exp) begin
            report_fail($sformatf("reg 0x%03h read 0x%08h, expected 0x%08h", addr, rd, exp));
        end
    endtask

    task automatic wait_tx_words(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (tx_seen.size() < target && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (tx_seen.size() < target) begin
            note_timeout("tx stream words");
        end
    endtask

    task automatic wait_credits_back(input int limit);
        int cycles;
        cycles = 0;
        while (credits_owed > 0 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (credits_owed > 0) begin
            note_timeout("tx credits to drain");
        end
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (irq !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (irq !== level) begin
            note_timeout("irq level change");
        end
    endtask

    // frame of len bytes, word err_idx flagged, data kept for checks if keep
    task automatic send_frame(input int len, input int err_idx, input bit keep);
        stream_word_t w;
        int           n;
        int           i;
        int           waited;
        n      = (len + 3) / 4;
        i      = 0;
        waited = 0;
        while (i < n && waited < 200) begin
            @(posedge clk);
            #1;
            if (rx_avail > 0) begin
                w        = '0;
                w.valid  = 1'b1;
                w.last   = (i == n - 1);
                w.error  = (i == err_idx);
                w.nbytes = (i == n - 1) ? 3'(len - 4 * (n - 1)) : 3'd4;
                w.data   = $urandom();
                rx_word  = w;
                if (keep) begin
                    rx_expect.push_back(w.data);
                end
                rx_avail--;
                words_sent++;
                i++;
            end else begin
                rx_word = '0;
                waited++;
            end
        end
        @(posedge clk);
        #1;
        rx_word = '0;
        if (i < n) begin
            note_timeout("rx credits to send a frame");
        end
    endtask

    task automatic read_rx_words(input int n);
        logic [31:0] rd;
        logic [31:0] exp;
        int          i;
        for (i = 0; i < n; i++) begin
            apb_read(addr_rxfifo, rd);
            if (rx_expect.size() > 0) begin
                exp = rx_expect.pop_front();
                if (rd !== exp) begin
                    report_fail($sformatf("rx word %0d is 0x%08h, expected 0x%08h", i, rd, exp));
                end
            end
        end
    endtask

    // nbytes and last follow from the frame length alone
    task automatic check_tx_words(input int base, input int len, input logic [31:0] words[$]);
        stream_word_t w;
        int           n;
        int           k;
        int           nb;
        n = (len + 3) / 4;
        for (k = 0; k < n && base + k < tx_seen.size(); k++) begin
            w  = tx_seen[base + k];
            nb = (k == n - 1) ? len - 4 * (n - 1) : 4;
            if (w.data !== words[k]) begin
                report_fail($sformatf("tx word %0d data 0x%08h, expected 0x%08h",
                                      k, w.data, words[k]));
            end
            if (w.nbytes !== 3'(nb)) begin
                report_fail($sformatf("tx word %0d nbytes %0d, expected %0d", k, w.nbytes, nb));
            end
            if (w.last !== (k == n - 1)) begin
                report_fail($sformatf("tx word %0d has last %0b", k, w.last));
            end
            if (w.error !== 1'b0) begin
                report_fail($sformatf("tx word %0d has error %0b", k, w.error));
            end
        end
    endtask

    task automatic test_reset_state();
        if (tx_word.valid !== 1'b0 || rx_credit !== 1'b0 || irq !== 1'b0) begin
            report_fail("tx valid, rx credit or irq not low after reset");
        end
        expect_reg(addr_status, 32'h0);
        expect_reg(addr_txlen, 32'h0);
        expect_reg(addr_rxlen, 32'h0);
        expect_reg(addr_ie, 32'h0);
        expect_reg(addr_txfifo, 32'hffff_ffff);
        finish_test("reset_state");
    endtask

    task automatic test_tx_frame();
        logic [31:0] words[$];
        logic [31:0] rd;
        int          base;
        int          i;
        base = tx_seen.size();
        apb_write(addr_txctrl, 32'h1);
        apb_write(addr_txlen, 32'd10);
        for (i = 0; i < 3; i++) begin
            words.push_back($urandom());
            apb_write(addr_txfifo, words[i]);
        end
        wait_tx_words(base + 3, 100);
        repeat (10) @(negedge clk);
        if (tx_seen.size() != base + 3) begin
            report_fail($sformatf("%0d tx words seen, expected 3", tx_seen.size() - base));
        end
        check_tx_words(base, 10, words);
        expect_reg(addr_txlen, 32'h0);
        apb_read(addr_ip, rd);
        if (rd[0] !== 1'b1) begin
            report_fail("IP bit 0 not set after the frame");
        end
        apb_write(addr_ie, 32'h1);
        if (irq !== 1'b1) begin
            report_fail("irq low with tx interrupt enabled");
        end
        apb_write(addr_ie, 32'h0);
        finish_test("tx_frame");
    endtask

    task automatic test_tx_backpressure();
        logic [31:0] words[$];
        int          base;
        int          i;
        bit          moved;
        wait_credits_back(50);
        hold_credits = 1'b1;
        base         = tx_seen.size();
        moved        = 1'b0;
        apb_write(addr_txlen, 32'd24);
        for (i = 0; i < 6; i++) begin
            words.push_back($urandom());
            apb_write(addr_txfifo, words[i]);
        end
        wait_tx_words(base + stream_credits, 100);
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            if (tx_word.valid) begin
                moved = 1'b1;
            end
        end
        if (moved || tx_seen.size() != base + stream_credits) begin
            report_fail("tx words sent without credits");
        end
        hold_credits = 1'b0;
        wait_tx_words(base + 6, 100);
        check_tx_words(base, 24, words);
        finish_test("tx_backpressure");
    endtask

    task automatic test_rx_frames();
        rx_expect.delete();
        apb_write(addr_rxctrl, 32'h1);
        send_frame(7, -1, 1'b1);
        send_frame(12, -1, 1'b1);
        apb_write(addr_ie, 32'h2);
        wait_irq(1'b1, 100);
        expect_reg(addr_rxlen, 32'd7);
        read_rx_words(2);
        apb_write(addr_rxdis, 32'h0);
        expect_reg(addr_rxlen, 32'd12);
        read_rx_words(3);
        apb_write(addr_rxdis, 32'h0);
        expect_reg(addr_rxlen, 32'h0);
        if (irq !== 1'b0) begin
            report_fail("irq still high with no frame left");
        end
        apb_write(addr_ie, 32'h0);
        finish_test("rx_frames");
    endtask

    task automatic test_rx_drops();
        logic [31:0] rd;
        int          sent0;
        int          cred0;
        int          polls;
        rx_expect.delete();
        sent0 = words_sent;
        cred0 = rx_credit_count;
        send_frame(12, 1, 1'b0);
        apb_write(addr_rxctrl, 32'h0);
        send_frame(8, -1, 1'b0);
        apb_write(addr_rxctrl, 32'h1);
        send_frame(8, -1, 1'b1);
        polls = 0;
        rd    = '0;
        while (rd == 32'h0 && polls < 20) begin
            apb_read(addr_rxlen, rd);
            polls++;
        end
        if (rd == 32'h0) begin
            note_timeout("the good rx frame");
        end else if (rd !== 32'd8) begin
            report_fail($sformatf("RXLEN read %0d, expected 8", rd));
        end
        read_rx_words(2);
        apb_write(addr_rxdis, 32'h0);
        expect_reg(addr_rxlen, 32'h0);
        if (rx_credit_count - cred0 != words_sent - sent0) begin
            report_fail($sformatf("%0d rx credits for %0d words",
                                  rx_credit_count - cred0, words_sent - sent0));
        end
        finish_test("rx_drops");
    endtask

    task automatic test_tx_discard();
        logic [31:0] words[$];
        int          base;
        base = tx_seen.size();
        apb_write(addr_txlen, 32'd16);
        apb_write(addr_txfifo, $urandom());
        apb_write(addr_txfifo, $urandom());
        apb_write(addr_txdis, 32'h0);
        repeat (30) @(negedge clk);
        if (tx_seen.size() != base) begin
            report_fail("tx words sent from a discarded frame");
        end
        expect_reg(addr_txlen, 32'h0);
        base = tx_seen.size();
        words.push_back($urandom());
        apb_write(addr_txlen, 32'd4);
        apb_write(addr_txfifo, words[0]);
        wait_tx_words(base + 1, 100);
        check_tx_words(base, 4, words);
        finish_test("tx_discard");
    endtask

    initial begin
        sw_rstn         = 1'b0;
        apb             = '0;
        tx_credit       = 1'b0;
        rx_word         = '0;
        hold_credits    = 1'b0;
        credits_owed    = 0;
        rx_avail        = stream_credits;
        rx_credit_count = 0;
        words_sent      = 0;
        test_errs       = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        timed_out       = 1'b0;
        void'($urandom(32'hc7e3_2172));
        repeat (8) @(posedge clk);
        #1;
        sw_rstn = 1'b1;
        test_reset_state();
        test_tx_frame();
        test_tx_backpressure();
        test_rx_frames();
        test_rx_drops();
        test_tx_discard();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
design/mac_reg_pkg.sv
design/mac_stream_pkg.sv
design/mac_apb_regs.sv
design/mac_frame_ram.sv
design/mac_tx_path.sv
design/mac_len_fifo.sv
design/mac_rx_path.sv
design/mac_top.sv
dv/mac_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module mac_tb -f list.f -o mac_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/mac_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
